// File: hw/periph_bus_pkg.sv
////////////////////
// Core bus widths and native size codes
// Imported by every block that sits on the peripheral bus
////////////////////
`default_nettype none

package periph_bus_pkg;

    // Core data word and byte lane widths
    localparam int DATA_W = 32;
    // Also the number of output and input pins
    localparam int BYTE_W = 8;

    // Native size codes for read and write requests
    localparam int SIZE_W = 2;
    localparam logic [SIZE_W-1:0] SIZE_BYTE = 2'b00;
    localparam logic [SIZE_W-1:0] SIZE_HALF = 2'b01;
    localparam logic [SIZE_W-1:0] SIZE_WORD = 2'b10;
    localparam logic [SIZE_W-1:0] SIZE_NONE = 2'b11;

endpackage

`default_nettype wire

// File: hw/periph_addr_pkg.sv
////////////////////
// Peripheral address map, slot numbers and register offsets
// The address union gives the full and byte region views of one address
////////////////////
`default_nettype none

package periph_addr_pkg;

    localparam int ADDR_W       = 11;
    localparam int SLOT_W       = 4;
    localparam int USER_OFS_W   = 6;
    localparam int SIMPLE_OFS_W = 4;

    // Populated slots in the full region
    localparam logic [SLOT_W-1:0] SLOT_GPIO   = 4'd1;
    localparam logic [SLOT_W-1:0] SLOT_USER_A = 4'd4;
    localparam logic [SLOT_W-1:0] SLOT_USER_B = 4'd5;

    // Populated slots in the byte region
    localparam logic [SLOT_W-1:0] SLOT_SIMPLE_A = 4'd0;
    localparam logic [SLOT_W-1:0] SLOT_SIMPLE_B = 4'd1;

    // GPIO register offsets, function selects are one per word from the base
    localparam logic [USER_OFS_W-1:0] GPIO_OUT_OFS   = 6'h00;
    localparam logic [USER_OFS_W-1:0] GPIO_IN_OFS    = 6'h04;
    localparam logic [USER_OFS_W-1:0] GPIO_FUNC_BASE = 6'h20;

    // Top bit picks the byte region, low bits pick the slot
    localparam int FUNC_W = 5;
    localparam logic [FUNC_W-1:0] FUNC_RESET = 5'd1;

    typedef struct packed {
        logic                    region;
        logic [SLOT_W-1:0]       slot;
        logic [USER_OFS_W-1:0]   ofs;
    } user_addr_t;

    typedef struct packed {
        logic                    region;
        logic [1:0]              spare;
        logic [SLOT_W-1:0]       slot;
        logic [SIMPLE_OFS_W-1:0] ofs;
    } simple_addr_t;

    typedef union packed {
        user_addr_t   user;
        simple_addr_t simple;
    } periph_addr_u;

endpackage

`default_nettype wire

// File: hw/user_example_reg.sv
////////////////////
// Example full interface peripheral
// One 32-bit register at offset 0 with byte, half and word writes
////////////////////
`timescale 1ns/10ps
`default_nettype none

module user_example_reg (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   i_wr,
    input  logic [periph_addr_pkg::USER_OFS_W-1:0] i_ofs,
    input  logic [periph_bus_pkg::SIZE_W-1:0]      i_size,
    input  logic [periph_bus_pkg::DATA_W-1:0]      i_wdata,
    output logic [periph_bus_pkg::DATA_W-1:0]      o_rdata,
    output logic [periph_bus_pkg::BYTE_W-1:0]      o_pins
);
    import periph_bus_pkg::*;

    logic [DATA_W-1:0] data_q;

    // Lanes above the write size keep their old value
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            data_q <= '0;
        end else if (i_wr && (i_ofs == '0)) begin
            case (i_size)
                SIZE_BYTE: data_q[BYTE_W-1:0]   <= i_wdata[BYTE_W-1:0];
                SIZE_HALF: data_q[2*BYTE_W-1:0] <= i_wdata[2*BYTE_W-1:0];
                SIZE_WORD: data_q               <= i_wdata;
                default: ;
            endcase
        end
    end

    assign o_rdata = (i_ofs == '0) ? data_q : '0;
    assign o_pins  = data_q[BYTE_W-1:0];

endmodule

`default_nettype wire

// File: hw/simple_example_reg.sv
////////////////////
// Example byte interface peripheral
// One byte register at offset 0, also driven to the pins
////////////////////
`timescale 1ns/10ps
`default_nettype none

module simple_example_reg (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic                                     i_wr,
    input  logic [periph_addr_pkg::SIMPLE_OFS_W-1:0] i_ofs,
    input  logic [periph_bus_pkg::BYTE_W-1:0]        i_wdata,
    output logic [periph_bus_pkg::BYTE_W-1:0]        o_rdata,
    output logic [periph_bus_pkg::BYTE_W-1:0]        o_pins
);
    import periph_bus_pkg::*;

    logic [BYTE_W-1:0] data_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            data_q <= '0;
        end else if (i_wr && (i_ofs == '0)) begin
            data_q <= i_wdata;
        end
    end

    assign o_rdata = (i_ofs == '0) ? data_q : '0;
    assign o_pins  = data_q;

endmodule

`default_nettype wire

// File: hw/gpio_block.sv
////////////////////
// GPIO output register, input pin readback and pin function selects
// Sits in full slot 1 and decodes its own register offsets
////////////////////
`timescale 1ns/10ps
`default_nettype none

module gpio_block (
    input  logic                                       clk,
    input  logic                                       rst_n,
    input  logic                                       i_wr,
    input  logic [periph_addr_pkg::USER_OFS_W-1:0]     i_ofs,
    input  logic [periph_bus_pkg::DATA_W-1:0]          i_wdata,
    input  logic [periph_bus_pkg::BYTE_W-1:0]          i_ui_in,
    output logic [periph_bus_pkg::DATA_W-1:0]          o_rdata,
    output logic [periph_bus_pkg::BYTE_W-1:0]          o_gpio_out,
    output logic [periph_bus_pkg::BYTE_W-1:0][periph_addr_pkg::FUNC_W-1:0] o_func_sel
);
    import periph_bus_pkg::*;
    import periph_addr_pkg::*;

    logic       func_hit;
    logic [2:0] func_idx;

    // Function selects occupy one word each above the base
    assign func_hit = (i_ofs[USER_OFS_W-1] == GPIO_FUNC_BASE[USER_OFS_W-1])
                      && (i_ofs[1:0] == 2'b00);
    assign func_idx = i_ofs[4:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            o_gpio_out <= '0;
            for (int i = 0; i < BYTE_W; i++) begin
                o_func_sel[i] <= FUNC_RESET;
            end
        end else if (i_wr) begin
            if (i_ofs == GPIO_OUT_OFS) begin
                o_gpio_out <= i_wdata[BYTE_W-1:0];
            end
            if (func_hit) begin
                o_func_sel[func_idx] <= i_wdata[FUNC_W-1:0];
            end
        end
    end

    // Readback is zero extended to the bus width
    always_comb begin
        o_rdata = '0;
        if (i_ofs == GPIO_OUT_OFS) begin
            o_rdata[BYTE_W-1:0] = o_gpio_out;
        end else if (i_ofs == GPIO_IN_OFS) begin
            o_rdata[BYTE_W-1:0] = i_ui_in;
        end else if (func_hit) begin
            o_rdata[FUNC_W-1:0] = o_func_sel[func_idx];
        end
    end

endmodule

`default_nettype wire

// File: hw/pin_mux.sv
////////////////////
// Output pin multiplexer
// Each pin takes its own bit from the peripheral its function select names
////////////////////
`timescale 1ns/10ps
`default_nettype none

module pin_mux (
    input  logic [periph_bus_pkg::BYTE_W-1:0][periph_addr_pkg::FUNC_W-1:0] i_func_sel,
    input  logic [periph_bus_pkg::BYTE_W-1:0] i_gpio_out,
    input  logic [periph_bus_pkg::BYTE_W-1:0] i_user_a_pins,
    input  logic [periph_bus_pkg::BYTE_W-1:0] i_user_b_pins,
    input  logic [periph_bus_pkg::BYTE_W-1:0] i_simple_a_pins,
    input  logic [periph_bus_pkg::BYTE_W-1:0] i_simple_b_pins,
    output logic [periph_bus_pkg::BYTE_W-1:0] o_uo_out
);
    import periph_bus_pkg::*;
    import periph_addr_pkg::*;

    always_comb begin
        logic [FUNC_W-1:0] sel;
        o_uo_out = '0;
        for (int i = 0; i < BYTE_W; i++) begin
            sel = i_func_sel[i];
            // Empty slots leave the pin low
            if (sel[FUNC_W-1]) begin
                case (sel[SLOT_W-1:0])
                    SLOT_SIMPLE_A: o_uo_out[i] = i_simple_a_pins[i];
                    SLOT_SIMPLE_B: o_uo_out[i] = i_simple_b_pins[i];
                    default:       o_uo_out[i] = 1'b0;
                endcase
            end else begin
                case (sel[SLOT_W-1:0])
                    SLOT_GPIO:   o_uo_out[i] = i_gpio_out[i];
                    SLOT_USER_A: o_uo_out[i] = i_user_a_pins[i];
                    SLOT_USER_B: o_uo_out[i] = i_user_b_pins[i];
                    default:     o_uo_out[i] = 1'b0;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/periph_ctrl.sv
////////////////////
// Bus controller for the peripheral wrapper
// Decodes the core address into slot strobes and muxes and holds read data
////////////////////
`timescale 1ns/10ps
`default_nettype none

module periph_ctrl (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  periph_addr_pkg::periph_addr_u         i_addr,
    input  logic [periph_bus_pkg::SIZE_W-1:0]     i_data_write_n,
    input  logic [periph_bus_pkg::SIZE_W-1:0]     i_data_read_n,
    input  logic                                  i_data_read_complete,
    input  logic [periph_bus_pkg::DATA_W-1:0]     i_rdata_gpio,
    input  logic [periph_bus_pkg::DATA_W-1:0]     i_rdata_user_a,
    input  logic [periph_bus_pkg::DATA_W-1:0]     i_rdata_user_b,
    input  logic [periph_bus_pkg::BYTE_W-1:0]     i_rdata_simple_a,
    input  logic [periph_bus_pkg::BYTE_W-1:0]     i_rdata_simple_b,
    output logic                                  o_wr_gpio,
    output logic                                  o_wr_user_a,
    output logic                                  o_wr_user_b,
    output logic                                  o_wr_simple_a,
    output logic                                  o_wr_simple_b,
    output logic [periph_addr_pkg::USER_OFS_W-1:0]   o_user_ofs,
    output logic [periph_addr_pkg::SIMPLE_OFS_W-1:0] o_simple_ofs,
    output logic [periph_bus_pkg::DATA_W-1:0]     o_data,
    output logic                                  o_data_ready
);
    import periph_bus_pkg::*;
    import periph_addr_pkg::*;

    logic              wr_req;
    logic              rd_req;
    logic [DATA_W-1:0] rdata_sel;
    logic [DATA_W-1:0] data_q;
    logic              hold_q;
    logic              ready_q;

    assign wr_req = (i_data_write_n != SIZE_NONE);
    assign rd_req = (i_data_read_n != SIZE_NONE);

    assign o_user_ofs   = i_addr.user.ofs;
    assign o_simple_ofs = i_addr.simple.ofs;

    // Slot decode, only populated slots get a strobe or a read value
    always_comb begin
        o_wr_gpio     = 1'b0;
        o_wr_user_a   = 1'b0;
        o_wr_user_b   = 1'b0;
        o_wr_simple_a = 1'b0;
        o_wr_simple_b = 1'b0;
        rdata_sel     = '0;
        if (i_addr.simple.region) begin
            case (i_addr.simple.slot)
                SLOT_SIMPLE_A: begin
                    o_wr_simple_a            = wr_req;
                    rdata_sel[BYTE_W-1:0]    = i_rdata_simple_a;
                end
                SLOT_SIMPLE_B: begin
                    o_wr_simple_b            = wr_req;
                    rdata_sel[BYTE_W-1:0]    = i_rdata_simple_b;
                end
                default: ;
            endcase
        end else begin
            case (i_addr.user.slot)
                SLOT_GPIO: begin
                    o_wr_gpio = wr_req;
                    rdata_sel = i_rdata_gpio;
                end
                SLOT_USER_A: begin
                    o_wr_user_a = wr_req;
                    rdata_sel   = i_rdata_user_a;
                end
                SLOT_USER_B: begin
                    o_wr_user_b = wr_req;
                    rdata_sel   = i_rdata_user_b;
                end
                default: ;
            endcase
        end
    end

    // Hold flag stays set until the core reports the read as taken
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold_q  <= 1'b0;
            ready_q <= 1'b0;
        end else begin
            if (i_data_read_complete) begin
                hold_q <= 1'b0;
            end
            if (rd_req && !hold_q) begin
                hold_q <= 1'b1;
            end
            ready_q <= rd_req;
        end
    end

    // New read data is ignored while a previous value is still held
    always_ff @(posedge clk) begin
        if (rd_req && !hold_q) begin
            data_q <= rdata_sel;
        end
    end

    assign o_data       = data_q;
    // Writes complete in the cycle they are presented
    assign o_data_ready = ready_q || wr_req;

endmodule

`default_nettype wire

// File: hw/periph_top.sv
////////////////////
// Peripheral wrapper top level on the core's native bus
// Connects the bus controller, GPIO, example peripherals and the pin mux
////////////////////
`timescale 1ns/10ps
`default_nettype none

module periph_top (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic [periph_bus_pkg::BYTE_W-1:0]  i_ui_in,
    output logic [periph_bus_pkg::BYTE_W-1:0]  o_uo_out,
    input  logic [periph_addr_pkg::ADDR_W-1:0] i_addr,
    input  logic [periph_bus_pkg::DATA_W-1:0]  i_data,
    input  logic [periph_bus_pkg::SIZE_W-1:0]  i_data_write_n,
    input  logic [periph_bus_pkg::SIZE_W-1:0]  i_data_read_n,
    output logic [periph_bus_pkg::DATA_W-1:0]  o_data,
    output logic                               o_data_ready,
    input  logic                               i_data_read_complete
);
    import periph_bus_pkg::*;
    import periph_addr_pkg::*;

    logic wr_gpio;
    logic wr_user_a;
    logic wr_user_b;
    logic wr_simple_a;
    logic wr_simple_b;

    logic [USER_OFS_W-1:0]   user_ofs;
    logic [SIMPLE_OFS_W-1:0] simple_ofs;

    logic [DATA_W-1:0] rdata_gpio;
    logic [DATA_W-1:0] rdata_user_a;
    logic [DATA_W-1:0] rdata_user_b;
    logic [BYTE_W-1:0] rdata_simple_a;
    logic [BYTE_W-1:0] rdata_simple_b;

    logic [BYTE_W-1:0] gpio_out;
    logic [BYTE_W-1:0] user_a_pins;
    logic [BYTE_W-1:0] user_b_pins;
    logic [BYTE_W-1:0] simple_a_pins;
    logic [BYTE_W-1:0] simple_b_pins;

    logic [BYTE_W-1:0][FUNC_W-1:0] func_sel;

    periph_ctrl u_ctrl (
        .clk                  (clk),
        .rst_n                (rst_n),
        .i_addr               (i_addr),
        .i_data_write_n       (i_data_write_n),
        .i_data_read_n        (i_data_read_n),
        .i_data_read_complete (i_data_read_complete),
        .i_rdata_gpio         (rdata_gpio),
        .i_rdata_user_a       (rdata_user_a),
        .i_rdata_user_b       (rdata_user_b),
        .i_rdata_simple_a     (rdata_simple_a),
        .i_rdata_simple_b     (rdata_simple_b),
        .o_wr_gpio            (wr_gpio),
        .o_wr_user_a          (wr_user_a),
        .o_wr_user_b          (wr_user_b),
        .o_wr_simple_a        (wr_simple_a),
        .o_wr_simple_b        (wr_simple_b),
        .o_user_ofs           (user_ofs),
        .o_simple_ofs         (simple_ofs),
        .o_data               (o_data),
        .o_data_ready         (o_data_ready)
    );

    gpio_block u_gpio (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_wr       (wr_gpio),
        .i_ofs      (user_ofs),
        .i_wdata    (i_data),
        .i_ui_in    (i_ui_in),
        .o_rdata    (rdata_gpio),
        .o_gpio_out (gpio_out),
        .o_func_sel (func_sel)
    );

    // Full slot 4
    user_example_reg u_user_a (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_wr    (wr_user_a),
        .i_ofs   (user_ofs),
        .i_size  (i_data_write_n),
        .i_wdata (i_data),
        .o_rdata (rdata_user_a),
        .o_pins  (user_a_pins)
    );

    // Full slot 5
    user_example_reg u_user_b (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_wr    (wr_user_b),
        .i_ofs   (user_ofs),
        .i_size  (i_data_write_n),
        .i_wdata (i_data),
        .o_rdata (rdata_user_b),
        .o_pins  (user_b_pins)
    );

    simple_example_reg u_simple_a (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_wr    (wr_simple_a),
        .i_ofs   (simple_ofs),
        .i_wdata (i_data[BYTE_W-1:0]),
        .o_rdata (rdata_simple_a),
        .o_pins  (simple_a_pins)
    );

    simple_example_reg u_simple_b (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_wr    (wr_simple_b),
        .i_ofs   (simple_ofs),
        .i_wdata (i_data[BYTE_W-1:0]),
        .o_rdata (rdata_simple_b),
        .o_pins  (simple_b_pins)
    );

    pin_mux u_pin_mux (
        .i_func_sel      (func_sel),
        .i_gpio_out      (gpio_out),
        .i_user_a_pins   (user_a_pins),
        .i_user_b_pins   (user_b_pins),
        .i_simple_a_pins (simple_a_pins),
        .i_simple_b_pins (simple_b_pins),
        .o_uo_out        (o_uo_out)
    );

endmodule

`default_nettype wire

// File: sim/tb_periph_top.sv
////////////////////
// Self-checking testbench for the peripheral wrapper
// Drives the native core bus and checks readback, pin routing and read hold
////////////////////
`timescale 1ns/10ps
`default_nettype none

module tb_periph_top;
    import periph_bus_pkg::*;
    import periph_addr_pkg::*;

    localparam int CLK_PERIOD     = 20;
    localparam int RESET_CYCLES   = 8;
    localparam int N_TESTS        = 6;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + N_TESTS * 40;

    logic              clk;
    logic              rst_n;
    logic [BYTE_W-1:0] ui_in;
    logic [BYTE_W-1:0] uo_out;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [SIZE_W-1:0] write_n;
    logic [SIZE_W-1:0] read_n;
    logic [DATA_W-1:0] rdata;
    logic              data_ready;
    logic              read_complete;
    logic [15:0]       lfsr_q;
    int                fail_count;

    // Expected contents of each peripheral
    logic [DATA_W-1:0]             user_a_exp;
    logic [DATA_W-1:0]             user_b_exp;
    logic [BYTE_W-1:0]             gpio_exp;
    logic [BYTE_W-1:0]             simple_a_exp;
    logic [BYTE_W-1:0]             simple_b_exp;
    logic [BYTE_W-1:0][FUNC_W-1:0] sel_exp;

    periph_top dut (
        .clk                  (clk),
        .rst_n                (rst_n),
        .i_ui_in              (ui_in),
        .o_uo_out             (uo_out),
        .i_addr               (addr),
        .i_data               (wdata),
        .i_data_write_n       (write_n),
        .i_data_read_n        (read_n),
        .o_data               (rdata),
        .o_data_ready         (data_ready),
        .i_data_read_complete (read_complete)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic stop_with_error(input string msg);
        fail_count++;
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_equal(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                               input string what);
        assert (got === exp)
            else stop_with_error($sformatf("CHECK FAILED at time %0t: %s got 0x%08h, expected 0x%08h",
                                           $time, what, got, exp));
    endtask

    // Writes never stall the core
    write_ready: assert property (@(posedge clk) disable iff (!rst_n)
        (write_n != SIZE_NONE) |-> data_ready)
        else stop_with_error($sformatf("CHECK FAILED at time %0t: write without o_data_ready",
                                       $time));

    // Held read data must not move until the core completes the read
    read_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (data_ready && (read_n != SIZE_NONE) && !read_complete) |=> $stable(rdata))
        else stop_with_error($sformatf("CHECK FAILED at time %0t: o_data changed during hold",
                                       $time));

    // 16-bit Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw_bits(input int nbits, output logic [DATA_W-1:0] value);
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            value  = {value[DATA_W-2:0], lfsr_q[0]};
        end
    endtask

    function automatic logic [ADDR_W-1:0] full_addr(input logic [SLOT_W-1:0] slot,
                                                    input logic [USER_OFS_W-1:0] ofs);
        return {1'b0, slot, ofs};
    endfunction

    function automatic logic [ADDR_W-1:0] byte_addr(input logic [SLOT_W-1:0] slot,
                                                    input logic [SIMPLE_OFS_W-1:0] ofs);
        return {1'b1, 2'b00, slot, ofs};
    endfunction

    function automatic logic [ADDR_W-1:0] func_addr(input int pin);
        return full_addr(SLOT_GPIO, USER_OFS_W'(GPIO_FUNC_BASE + 4 * pin));
    endfunction

    // Sized write model where untouched lanes keep their old bytes
    function automatic logic [DATA_W-1:0] merge_lanes(input logic [DATA_W-1:0] old,
                                                      input logic [DATA_W-1:0] wd,
                                                      input logic [SIZE_W-1:0] size);
        logic [DATA_W-1:0] mask;
        case (size)
            SIZE_BYTE: mask = 32'h0000_00ff;
            SIZE_HALF: mask = 32'h0000_ffff;
            SIZE_WORD: mask = 32'hffff_ffff;
            default:   mask = '0;
        endcase
        return (old & ~mask) | (wd & mask);
    endfunction

    function automatic logic [BYTE_W-1:0] source_byte(input logic [FUNC_W-1:0] sel);
        logic [BYTE_W-1:0] src;
        src = '0;
        if (sel == {1'b1, SLOT_SIMPLE_A}) src = simple_a_exp;
        if (sel == {1'b1, SLOT_SIMPLE_B}) src = simple_b_exp;
        if (sel == {1'b0, SLOT_GPIO})     src = gpio_exp;
        if (sel == {1'b0, SLOT_USER_A})   src = user_a_exp[BYTE_W-1:0];
        if (sel == {1'b0, SLOT_USER_B})   src = user_b_exp[BYTE_W-1:0];
        return src;
    endfunction

    function automatic logic [BYTE_W-1:0] expected_pins();
        logic [BYTE_W-1:0] pins;
        logic [BYTE_W-1:0] src;
        for (int i = 0; i < BYTE_W; i++) begin
            src     = source_byte(sel_exp[i]);
            pins[i] = src[i];
        end
        return pins;
    endfunction

    task automatic wait_ready(input string what);
        int cycles = 0;
        @(negedge clk);
        while (!data_ready) begin
            cycles++;
            if (cycles > 10) begin
                stop_with_error($sformatf("No o_data_ready for the %s within 10 cycles", what));
            end
            @(negedge clk);
        end
    endtask

    task automatic bus_write(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d,
                             input logic [SIZE_W-1:0] size);
        @(posedge clk);
        #1;
        addr    = a;
        wdata   = d;
        write_n = size;
        wait_ready("write");
        @(posedge clk);
        #1;
        write_n = SIZE_NONE;
    endtask

    task automatic bus_read(input logic [ADDR_W-1:0] a, input logic [SIZE_W-1:0] size,
                            output logic [DATA_W-1:0] data);
        @(posedge clk);
        #1;
        addr   = a;
        read_n = size;
        wait_ready("read");
        data = rdata;
        @(posedge clk);
        #1;
        read_n        = SIZE_NONE;
        read_complete = 1'b1;
        @(posedge clk);
        #1;
        read_complete = 1'b0;
    endtask

    task automatic check_read(input logic [ADDR_W-1:0] a, input logic [SIZE_W-1:0] size,
                              input logic [DATA_W-1:0] exp, input string what);
        logic [DATA_W-1:0] got;
        bus_read(a, size, got);
        check_equal(got, exp, what);
    endtask

    task automatic set_func(input int pin, input logic [FUNC_W-1:0] sel);
        bus_write(func_addr(pin), DATA_W'(sel), SIZE_WORD);
        sel_exp[pin] = sel;
    endtask

    task automatic check_pins(input string what);
        @(negedge clk);
        check_equal(uo_out, expected_pins(), what);
    endtask

    initial begin
        logic [DATA_W-1:0] rnd;
        logic [SIZE_W-1:0] sizes [3];
        logic [FUNC_W-1:0] srcs [BYTE_W];
        clk           = 1'b0;
        rst_n         = 1'b0;
        ui_in         = '0;
        addr          = '0;
        wdata         = '0;
        write_n       = SIZE_NONE;
        read_n        = SIZE_NONE;
        read_complete = 1'b0;
        lfsr_q        = 16'd41900;
        fail_count    = 0;
        user_a_exp    = '0;
        user_b_exp    = '0;
        gpio_exp      = '0;
        simple_a_exp  = '0;
        simple_b_exp  = '0;
        for (int i = 0; i < BYTE_W; i++) begin
            sel_exp[i] = FUNC_RESET;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Reset state
        @(negedge clk);
        check_equal(uo_out, '0, "o_uo_out after reset");
        check_equal(data_ready, '0, "o_data_ready with no request");
        for (int i = 0; i < BYTE_W; i++) begin
            check_read(func_addr(i), SIZE_WORD, FUNC_RESET,
                       $sformatf("function select %0d after reset", i));
        end

        // GPIO output and input readback
        draw_bits(DATA_W, rnd);
        bus_write(full_addr(SLOT_GPIO, GPIO_OUT_OFS), rnd, SIZE_WORD);
        gpio_exp = rnd[BYTE_W-1:0];
        check_read(full_addr(SLOT_GPIO, GPIO_OUT_OFS), SIZE_WORD, gpio_exp, "GPIO out readback");
        check_pins("pins driven by GPIO");
        draw_bits(BYTE_W, rnd);
        @(posedge clk);
        #1;
        ui_in = rnd[BYTE_W-1:0];
        check_read(full_addr(SLOT_GPIO, GPIO_IN_OFS), SIZE_WORD, ui_in, "GPIO input readback");

        // Sized writes to user slot A while slot B stays at reset
        sizes = '{SIZE_WORD, SIZE_BYTE, SIZE_HALF};
        foreach (sizes[k]) begin
            draw_bits(DATA_W, rnd);
            bus_write(full_addr(SLOT_USER_A, '0), rnd, sizes[k]);
            user_a_exp = merge_lanes(user_a_exp, rnd, sizes[k]);
            check_read(full_addr(SLOT_USER_A, '0), SIZE_WORD, user_a_exp,
                       $sformatf("user slot A after write size %0d", sizes[k]));
        end
        check_read(full_addr(SLOT_USER_B, '0), SIZE_WORD, user_b_exp, "user slot B untouched");

        // Byte slots and pin routing
        draw_bits(BYTE_W, rnd);
        bus_write(byte_addr(SLOT_SIMPLE_A, '0), rnd, SIZE_BYTE);
        simple_a_exp = rnd[BYTE_W-1:0];
        draw_bits(BYTE_W, rnd);
        bus_write(byte_addr(SLOT_SIMPLE_B, '0), rnd, SIZE_BYTE);
        simple_b_exp = rnd[BYTE_W-1:0];
        check_read(byte_addr(SLOT_SIMPLE_A, '0), SIZE_BYTE, simple_a_exp, "byte slot A");
        check_read(byte_addr(SLOT_SIMPLE_B, '0), SIZE_BYTE, simple_b_exp, "byte slot B");
        draw_bits(DATA_W, rnd);
        bus_write(full_addr(SLOT_USER_B, '0), rnd, SIZE_WORD);
        user_b_exp = rnd;
        // Every source plus one empty slot in each region
        srcs = '{{1'b1, SLOT_SIMPLE_A}, {1'b1, SLOT_SIMPLE_B}, {1'b0, SLOT_USER_A},
                 {1'b0, SLOT_USER_B}, {1'b0, SLOT_GPIO}, {1'b1, 4'd7}, {1'b0, 4'd9},
                 {1'b1, SLOT_SIMPLE_B}};
        for (int pass = 0; pass < 2; pass++) begin
            for (int i = 0; i < BYTE_W; i++) begin
                set_func(i, srcs[(i + 3 * pass) % BYTE_W]);
            end
            check_pins($sformatf("pin map %0d", pass));
        end

        // Read latency and hold while the address moves
        @(posedge clk);
        #1;
        addr   = full_addr(SLOT_USER_A, '0);
        read_n = SIZE_WORD;
        @(negedge clk);
        check_equal(data_ready, '0, "o_data_ready in the request cycle");
        @(negedge clk);
        check_equal(data_ready, 1'b1, "o_data_ready one cycle after the request");
        check_equal(rdata, user_a_exp, "captured read data");
        @(posedge clk);
        #1;
        addr = full_addr(SLOT_USER_B, '0);
        repeat (2) @(negedge clk);
        check_equal(data_ready, 1'b1, "o_data_ready while the request persists");
        check_equal(rdata, user_a_exp, "held data after address change");
        @(posedge clk);
        #1;
        read_n        = SIZE_NONE;
        read_complete = 1'b1;
        @(posedge clk);
        #1;
        read_complete = 1'b0;
        check_read(full_addr(SLOT_USER_B, '0), SIZE_WORD, user_b_exp, "read after completion");

        // Empty slots
        check_read(full_addr(4'd9, 6'h00), SIZE_WORD, '0, "empty full slot");
        check_read(byte_addr(4'd7, 4'h0), SIZE_BYTE, '0, "empty byte slot");

        if (fail_count == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            $display("CHECKS FAILED");
            $fatal(1, "Errors were recorded during the run");
        end
    end

    // Watchdog
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        stop_with_error($sformatf("Timeout: the run did not end within %0d clock cycles",
                                  TIMEOUT_CYCLES));
    end

endmodule

`default_nettype wire

// File: vlog.f
hw/periph_bus_pkg.sv
hw/periph_addr_pkg.sv
hw/user_example_reg.sv
hw/simple_example_reg.sv
hw/gpio_block.sv
hw/pin_mux.sv
hw/periph_ctrl.sv
hw/periph_top.sv
sim/tb_periph_top.sv

// File: Bender.yml
package:
  name: periph_wrapper

sources:
  - hw/periph_bus_pkg.sv
  - hw/periph_addr_pkg.sv
  - hw/user_example_reg.sv
  - hw/simple_example_reg.sv
  - hw/gpio_block.sv
  - hw/pin_mux.sv
  - hw/periph_ctrl.sv
  - hw/periph_top.sv
  - target: simulation
    files:
      - sim/tb_periph_top.sv
